// File: verilog/miniAlu_defs.svh
`ifndef MINIALU_DEFS_SVH
`define MINIALU_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// instruction format.
`define INSTR_W     28
`define OP_W        4
`define DATA_W      16
`define ADDR_W      8
`define RAM_DEPTH   256

// ~~~~~~~~~~~~~~~~~~~~
// opcode values.
`define OP_NOP      4'd0
`define OP_ADD      4'd1
`define OP_SUB      4'd2
`define OP_STO      4'd3
`define OP_BLE      4'd4
`define OP_JMP      4'd5
`define OP_LED      4'd6
`define OP_IMUL     4'd7
`define OP_SMUL     4'd8

`endif

// File: verilog/miniAluPkg.sv
`include "miniAlu_defs.svh"

package miniAluPkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// operations understood by the execute unit.
	typedef enum logic [`OP_W-1:0]
	{
		opNop  = `OP_NOP,
		opAdd  = `OP_ADD,
		opSub  = `OP_SUB,
		opSto  = `OP_STO,
		opBle  = `OP_BLE,
		opJmp  = `OP_JMP,
		opLed  = `OP_LED,
		opImul = `OP_IMUL,
		opSmul = `OP_SMUL
	} opcodeT;

	// register form, used by arithmetic, branches and LED.
	typedef struct packed
	{
		opcodeT              op;
		logic [`ADDR_W-1:0]  dest;   // write address or branch target.
		logic [`ADDR_W-1:0]  src1;
		logic [`ADDR_W-1:0]  src0;
	} regFormT;

	// immediate form, used by STO only.
	typedef struct packed
	{
		opcodeT              op;
		logic [`ADDR_W-1:0]  dest;
		logic [`DATA_W-1:0]  imm;    // overlays src1 and src0.
	} immFormT;

	// one fetched word, read through whichever view the opcode needs.
	typedef union packed
	{
		regFormT regForm;
		immFormT immForm;
	} instrT;

	// ~~~~~~~~~~~~~~~~~~~~
	// write request from the execute unit into the data RAM.
	typedef struct packed
	{
		logic                en;
		logic [`ADDR_W-1:0]  addr;
		logic [`DATA_W-1:0]  data;
	} writeBackT;

endpackage

// File: verilog/dataRam.sv
`timescale 1ns/1ps
`include "miniAlu_defs.svh"

module dataRam
(
	input  logic                   Clock,
	input  logic                   rstN,
	input  logic [`ADDR_W-1:0]     readAddr0,
	input  logic [`ADDR_W-1:0]     readAddr1,
	input  miniAluPkg::writeBackT  writeBack,
	output logic [`DATA_W-1:0]     readData0,
	output logic [`DATA_W-1:0]     readData1
);

	logic [`DATA_W-1:0] mem [`RAM_DEPTH];

	// storage array, one write port.
	always_ff @(posedge Clock)
	begin
		if (writeBack.en)
			mem[writeBack.addr] <= writeBack.data;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// registered read ports. A read that hits the word being written this cycle
	// sees the new value, so dependent instructions can issue back to back.
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			readData0 <= '0;
			readData1 <= '0;
		end
		else
		begin
			readData0 <= (writeBack.en && writeBack.addr == readAddr0) ?
				writeBack.data : mem[readAddr0];
			readData1 <= (writeBack.en && writeBack.addr == readAddr1) ?
				writeBack.data : mem[readAddr1];
		end
	end

	aWriteAddrKnown: assert property (@(posedge Clock) disable iff (!rstN)
		writeBack.en |-> !$isunknown(writeBack.addr));

endmodule

// File: verilog/instPointer.sv
`timescale 1ns/1ps
`include "miniAlu_defs.svh"

module instPointer
(
	input  logic               Clock,
	input  logic               rstN,
	input  logic               branchTaken,
	input  logic [`ADDR_W-1:0] branchTarget,
	output logic [`ADDR_W-1:0] instrAddr
);

	logic [`ADDR_W-1:0] ptrQ;   // address of the next sequential fetch.

	// ~~~~~~~~~~~~~~~~~~~~
	// a taken branch redirects the fetch in the same cycle.
	// There is no delay slot.
	always_comb
	begin
		if (branchTaken)
			instrAddr = branchTarget;
		else
			instrAddr = ptrQ;
	end

	// the register always runs one ahead of whatever was just fetched.
	always_ff @(posedge Clock)
	begin
		if (!rstN)
			ptrQ <= '0;
		else
			ptrQ <= instrAddr + `ADDR_W'd1;   // wraps at the top of program space.
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// fetch must restart at address zero once reset is released.
	aResetToZero: assert property (@(posedge Clock)
		!rstN |=> instrAddr == '0);

endmodule

// File: verilog/arrayMultiplier.sv
`timescale 1ns/1ps

module arrayMultiplier
(
	input  logic [7:0]  a,
	input  logic [7:0]  b,
	output logic [15:0] product
);

	wire [7:0] pp [8];        // pp[i][j] is a[j] and b[i].
	wire [8:0] rowSum [8];    // row result, carry out in bit 8.

	genvar i, j;

	// ~~~~~~~~~~~~~~~~~~~~
	// partial product rows.
	for (i = 0; i < 8; i++)
	begin : gPartial
		assign pp[i] = a & {8{b[i]}};
	end

	assign rowSum[0] = {1'b0, pp[0]};

	// each row adds its partial product to the previous row shifted down by one.
	// The bit shifted out is final and drops into the product.
	for (i = 1; i < 8; i++)
	begin : gRow
		wire [8:0] carry;
		assign carry[0] = 1'b0;
		for (j = 0; j < 8; j++)
		begin : gCell
			assign rowSum[i][j] = pp[i][j] ^ rowSum[i-1][j+1] ^ carry[j];   // full adder sum.
			assign carry[j+1] = (pp[i][j] & rowSum[i-1][j+1]) |
				(carry[j] & (pp[i][j] ^ rowSum[i-1][j+1]));
		end
		assign rowSum[i][8] = carry[8];
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// low bits come one per row, the top byte from the last row.
	for (i = 0; i < 8; i++)
	begin : gLowBits
		assign product[i] = rowSum[i][0];
	end

	assign product[15:8] = rowSum[7][8:1];

endmodule

// File: verilog/execUnit.sv
`timescale 1ns/1ps
`include "miniAlu_defs.svh"

module execUnit
(
	input  logic                   Clock,
	input  logic                   rstN,
	input  miniAluPkg::instrT      instr,
	input  logic [`DATA_W-1:0]     operand0,
	input  logic [`DATA_W-1:0]     operand1,
	output miniAluPkg::writeBackT  writeBack,
	output logic                   branchTaken,
	output logic [`ADDR_W-1:0]     branchTarget,
	output logic [7:0]             led,
	output logic                   ledWrite
);

	miniAluPkg::instrT          decodeQ;         // instruction in execute.
	logic [15:0]                arrayProduct;
	logic signed [`DATA_W-1:0]  signedProduct;
	logic [`DATA_W-1:0]         result;
	logic                       writeEn;
	logic                       ledLoad;

	// ~~~~~~~~~~~~~~~~~~~~
	// decode stage. An all-zero word decodes as NOP.
	always_ff @(posedge Clock)
	begin
		if (!rstN)
			decodeQ <= '0;
		else
			decodeQ <= instr;
	end

	arrayMultiplier uArrayMul
	(
		.a       (operand1[7:0]),
		.b       (operand0[7:0]),
		.product (arrayProduct)
	);

	assign signedProduct = $signed(operand1) * $signed(operand0);   // low half is kept.

	// ~~~~~~~~~~~~~~~~~~~~
	// operation select.
	always_comb
	begin
		result      = '0;
		writeEn     = 1'b0;
		branchTaken = 1'b0;
		ledLoad     = 1'b0;
		case (decodeQ.regForm.op)
			miniAluPkg::opAdd:
			begin
				result  = operand1 + operand0;   // wraps modulo 2^16.
				writeEn = 1'b1;
			end
			miniAluPkg::opSub:
			begin
				result  = operand1 - operand0;
				writeEn = 1'b1;
			end
			miniAluPkg::opSto:
			begin
				result  = decodeQ.immForm.imm;
				writeEn = 1'b1;
			end
			miniAluPkg::opImul:
			begin
				result  = arrayProduct;
				writeEn = 1'b1;
			end
			miniAluPkg::opSmul:
			begin
				result  = signedProduct;
				writeEn = 1'b1;
			end
			miniAluPkg::opBle:
				branchTaken = (operand1 <= operand0);   // unsigned compare.
			miniAluPkg::opJmp:
				branchTaken = 1'b1;
			miniAluPkg::opLed:
				ledLoad = 1'b1;
			default:
			begin
				// NOP and any unused opcode leave all state alone.
			end
		endcase
	end

	assign writeBack.en   = writeEn;
	assign writeBack.addr = decodeQ.regForm.dest;
	assign writeBack.data = result;
	assign branchTarget   = decodeQ.regForm.dest;

	// ~~~~~~~~~~~~~~~~~~~~
	// LED register and its load strobe.
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			led      <= '0;
			ledWrite <= 1'b0;
		end
		else
		begin
			ledWrite <= ledLoad;
			if (ledLoad)
				led <= operand1[7:0];
		end
	end

	aLedFromLedOp: assert property (@(posedge Clock) disable iff (!rstN)
		ledWrite |-> $past(decodeQ.regForm.op == miniAluPkg::opLed));

	// a branch never writes the RAM.
	aNoBranchWrite: assert property (@(posedge Clock) disable iff (!rstN)
		!(branchTaken && writeBack.en));

endmodule

// File: verilog/miniAlu.sv
`timescale 1ns/1ps
`include "miniAlu_defs.svh"

module miniAlu
(
	input  logic               Clock,
	input  logic               rstN,
	input  miniAluPkg::instrT  instr,       // from program memory, same cycle.
	output logic [`ADDR_W-1:0] instrAddr,
	output logic [7:0]         led,
	output logic               ledWrite
);

	logic                      branchTaken;
	logic [`ADDR_W-1:0]        branchTarget;
	logic [`DATA_W-1:0]        operand0;
	logic [`DATA_W-1:0]        operand1;
	miniAluPkg::writeBackT     writeBack;

	// ~~~~~~~~~~~~~~~~~~~~
	// fetch.
	instPointer uInstPointer
	(
		.Clock        (Clock),
		.rstN         (rstN),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.instrAddr    (instrAddr)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// operand read. The raw source fields address the RAM during fetch, so
	// the data lines up with the decode register one cycle later.
	dataRam uDataRam
	(
		.Clock     (Clock),
		.rstN      (rstN),
		.readAddr0 (instr.regForm.src0),
		.readAddr1 (instr.regForm.src1),
		.writeBack (writeBack),
		.readData0 (operand0),
		.readData1 (operand1)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// execute and writeback.
	execUnit uExecUnit
	(
		.Clock        (Clock),
		.rstN         (rstN),
		.instr        (instr),
		.operand0     (operand0),
		.operand1     (operand1),
		.writeBack    (writeBack),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.led          (led),
		.ledWrite     (ledWrite)
	);

endmodule

// File: verif/miniAluChecker.sv
`timescale 1ns/1ps
`include "miniAlu_defs.svh"

module miniAluChecker
(
	input  logic       Clock,
	input  logic       rstN,
	input  logic [7:0] led,
	input  logic       ledWrite,
	input  logic [7:0] expected [`RAM_DEPTH],
	input  int         expCount,
	output int         passCount,
	output int         failCount,
	output logic       finished
);

	localparam int TAIL_CYCLES = 20;   // quiet cycles after the last byte, so a stray pulse shows.

	logic inReset = 1'b1;   // rstN as it stood at the last rising edge.
	logic done = 1'b0;
	int   passes = 0;
	int   fails = 0;
	int   seen = 0;         // LED pulses observed so far.
	int   cycles = 0;
	int   quiet = 0;

	assign passCount = passes;
	assign failCount = fails;
	assign finished  = done;

	task automatic reportMismatch
	(
		input string      name,
		input logic [7:0] want,
		input logic [7:0] got
	);
		$display("Fail at %0t: %s expected %h, got %h", $time, name, want, got);
		fails++;
	endtask

	always @(posedge Clock)
		inReset <= !rstN;

	// ~~~~~~~~~~~~~~~~~~~~
	// outputs settle after the rising edge, so they are sampled on the falling one.
	always @(negedge Clock)
	begin
		if (!done && inReset)
		begin
			if (led !== 8'h00)
				reportMismatch("led", 8'h00, led);
			if (ledWrite !== 1'b0)
				reportMismatch("ledWrite", 8'h00, {7'b0, ledWrite});
		end
		else if (!done)
		begin
			cycles++;
			if (ledWrite === 1'b1)
			begin
				if (seen >= expCount)
				begin
					$display("An extra LED write at %0t showed %h after all expected values.",
						$time, led);
					fails++;
				end
				else if (led === expected[seen])
				begin
					$display("Test %0d passed: led %h at %0t", seen + 1, led, $time);
					passes++;
				end
				else
					reportMismatch("led", expected[seen], led);
				seen++;
			end
			if (seen >= expCount)
				quiet++;   // counts up only once every byte has been seen.
			if (cycles >= 64 * expCount + 100)
			begin
				$display("Timeout: %0d of %0d LED values seen within %0d cycles.",
					seen, expCount, cycles);
				fails++;
				done = 1'b1;
			end
			else if (quiet >= TAIL_CYCLES)
				done = 1'b1;
		end
	end

endmodule

// File: verif/miniAluTb.sv
`timescale 1ns/1ps
`include "miniAlu_defs.svh"

module miniAluTb;

	localparam int VEC_DEPTH = 2 * `RAM_DEPTH + 2;   // two counts, program and expected bytes.

	logic                Clock = 1'b0;
	logic                rstN = 1'b0;
	miniAluPkg::instrT   instr = '0;
	logic [`ADDR_W-1:0]  instrAddr;
	logic [7:0]          led;
	logic                ledWrite;

	logic [`INSTR_W-1:0] vectors [VEC_DEPTH];
	logic [`INSTR_W-1:0] progMem [`RAM_DEPTH];
	logic [7:0]          expected [`RAM_DEPTH];
	int                  progCount = 0;
	int                  expCount = 0;
	logic                loadOk = 1'b0;
	int                  passCount;
	int                  failCount;
	logic                finished;

	always #5 Clock = ~Clock;

	miniAlu dut
	(
		.Clock     (Clock),
		.rstN      (rstN),
		.instr     (instr),
		.instrAddr (instrAddr),
		.led       (led),
		.ledWrite  (ledWrite)
	);

	miniAluChecker uChecker
	(
		.Clock     (Clock),
		.rstN      (rstN),
		.led       (led),
		.ledWrite  (ledWrite),
		.expected  (expected),
		.expCount  (expCount),
		.passCount (passCount),
		.failCount (failCount),
		.finished  (finished)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// program memory. instrAddr only moves after a rising edge, so it is settled here.
	always @(negedge Clock)
	begin
		instr = progMem[instrAddr];
		$display("fetch %h: %s dest %h src1 %h src0 %h", instrAddr,
			instr.regForm.op.name(), instr.regForm.dest, instr.regForm.src1,
			instr.regForm.src0);
	end

	initial
	begin
		$timeformat(-9, 0, " ns", 0);
		$readmemh("verif/miniAluVectors.hex", vectors);
		for (int i = 0; i < `RAM_DEPTH; i++)
		begin
			progMem[i]  = {`OP_JMP, 8'(i), 16'h0000};   // unused words park the core in place.
			expected[i] = 8'h00;
		end
		if (!$isunknown(vectors[0]) && vectors[0] > 0 && vectors[0] <= `RAM_DEPTH)
		begin
			progCount = int'(vectors[0]);
			if (!$isunknown(vectors[progCount + 1]) && vectors[progCount + 1] <= `RAM_DEPTH)
			begin
				expCount = int'(vectors[progCount + 1]);
				loadOk   = 1'b1;
			end
		end
		for (int i = 0; i < progCount; i++)
			progMem[i] = vectors[i + 1];
		for (int i = 0; i < expCount; i++)
			expected[i] = vectors[progCount + 2 + i][7:0];

		// ~~~~~~~~~~~~~~~~~~~~
		if (loadOk)
		begin
			repeat (8) @(negedge Clock);
			rstN = 1'b1;
			wait (finished);
			$display("Tests done: %0d passed, %0d failed", passCount, failCount);
		end
		else
			$display("The vectors file is missing or holds counts out of range.");
		if (loadOk && failCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: verif/miniAluVectors.hex
// program word count, then the words (op dest src1 src0, or op dest imm for STO),
// then the expected LED byte count and the bytes in the order they appear.
20
3101234   // 00 STO [10] = 1234
6001000   // 01 LED [10]
3110005   // 02 STO [11] = 0005
3120007   // 03 STO [12] = 0007
2131112   // 04 SUB [13] = [11] - [12], below zero
6001300   // 05 LED [13]
314FFF0   // 06 STO [14] = FFF0
3150025   // 07 STO [15] = 0025
1161415   // 08 ADD [16] = [14] + [15], past 16 bits
6001600   // 09 LED [16], reads the value written just before
1171616   // 0A ADD [17] = [16] + [16]
1171710   // 0B ADD [17] = [17] + [10], back to back on [17]
6001700   // 0C LED [17]
32000C8   // 0D STO [20] = 00C8
3210133   // 0E STO [21] = 0133
7222021   // 0F IMUL [22] = C8 * 33
6002200   // 10 LED [22]
323FFF9   // 11 STO [23] = FFF9
3240013   // 12 STO [24] = 0013
8252324   // 13 SMUL [25] = -7 * 19
6002500   // 14 LED [25]
3300001   // 15 STO [30] = 1, loop counter
3310003   // 16 STO [31] = 3, loop limit
3320001   // 17 STO [32] = 1
6003000   // 18 LED [30], loop top
1303032   // 19 ADD [30] = [30] + [32]
4183031   // 1A BLE 18 while [30] <= [31]
51D0000   // 1B JMP 1D
6001300   // 1C LED [13], skipped
33300A5   // 1D STO [33] = 00A5
6003300   // 1E LED [33]
51F0000   // 1F JMP 1F, end of program
0A
34 FE 15 5E D8
7B 01 02 03 A5

// File: filelist.f
+incdir+verilog
verilog/miniAluPkg.sv
verilog/dataRam.sv
verilog/instPointer.sv
verilog/arrayMultiplier.sv
verilog/execUnit.sv
verilog/miniAlu.sv
verif/miniAluChecker.sv
verif/miniAluTb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert --top-module miniAluTb -f filelist.f -o miniAluSim \
	&& ./obj_dir/miniAluSim > sim.log
cat sim.log 2>/dev/null
grep -q "Verification passed" sim.log && echo "simulation PASSED" \
	|| { echo "simulation FAILED"; exit 1; }
